//--- source/mips_defs.svh
// core widths, reset address and instruction field bounds
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data path and register index widths
`define REG_W           32
`define REG_ADDR_W      5

// first fetch address
`define RESET_PC        32'h0000_0000

// instruction word fields
`define OPCODE_MSB      31
`define OPCODE_LSB      26
`define RS_MSB          25
`define RS_LSB          21
`define RT_MSB          20
`define RT_LSB          16
`define RD_MSB          15
`define RD_LSB          11
`define SHAMT_MSB       10
`define SHAMT_LSB       6
`define FUNCT_MSB       5
`define FUNCT_LSB       0
`define IMM_MSB         15
`define IMM_LSB         0

`endif

//--- source/mips_pkg.sv
// opcode, funct, alu and memory enums plus the pipeline stage structs
`default_nettype none
`include "mips_defs.svh"

package mips_pkg;

typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
} opcode_e;

typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
} funct_e;

typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
} alu_op_e;

typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
} mem_op_e;

typedef struct packed {
        logic [`REG_W-1:0]      pc;
        logic [`REG_W-1:0]      inst;
} if_id_t;

typedef struct packed {
        logic [`REG_W-1:0]      pc;
        alu_op_e                alu_op;
        mem_op_e                mem_op;
        logic [`REG_W-1:0]      op_a;
        logic [`REG_W-1:0]      op_b;
        logic [`REG_W-1:0]      store_data;
        logic                   we;
        logic [`REG_ADDR_W-1:0] dest;
} id_ex_t;

typedef struct packed {
        logic [`REG_W-1:0]      pc;
        mem_op_e                mem_op;
        // alu result, or the address for loads and stores
        logic [`REG_W-1:0]      result;
        logic [`REG_W-1:0]      store_data;
        logic                   we;
        logic [`REG_ADDR_W-1:0] dest;
} ex_mem_t;

typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`REG_W-1:0]      value;
} bypass_t;

typedef struct packed {
        logic                   ce;
        logic                   we;
        logic [`REG_W-1:0]      addr;
        logic [`REG_W-1:0]      wdata;
} dmem_req_t;

typedef struct packed {
        logic [`REG_W-1:0]      pc;
        logic                   we;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`REG_W-1:0]      data;
} wb_debug_t;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
// program counter and the IF/ID pipeline register
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module fetch_stage (
        input  wire                     clk,
        input  wire                     rst_i,
        input  wire                     stall_i,
        input  wire [`REG_W-1:0]        rom_data_i,
        output logic [`REG_W-1:0]       rom_addr_o,
        output logic                    rom_ce_o,
        output mips_pkg::if_id_t        if_id_o
);

logic [`REG_W-1:0] pc;

// fetch enable comes up one cycle after reset
always_ff @(posedge clk)
begin
        if (rst_i)
                rom_ce_o <= 1'b0;
        else
                rom_ce_o <= 1'b1;
end

always_ff @(posedge clk)
begin
        if (rst_i || !rom_ce_o)
                pc <= `RESET_PC;
        else if (!stall_i)
                pc <= pc + 32'd4;
end

assign rom_addr_o = pc;

// nop while idle, hold on load-use stall
always_ff @(posedge clk)
begin
        if (rst_i || !rom_ce_o)
        begin
                if_id_o.pc   <= `RESET_PC;
                if_id_o.inst <= '0;
        end
        else if (!stall_i)
        begin
                if_id_o.pc   <= pc;
                if_id_o.inst <= rom_data_i;
        end
end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// instruction decode, operand bypass, load-use interlock and the ID/EX register
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module decode_stage (
        input  wire                             clk,
        input  wire                             rst_i,
        input  wire mips_pkg::if_id_t           if_id_i,
        input  wire [`REG_W-1:0]                rs_data_i,
        input  wire [`REG_W-1:0]                rt_data_i,
        input  wire mips_pkg::bypass_t          ex_bypass_i,
        input  wire mips_pkg::bypass_t          mem_bypass_i,
        input  wire                             ex_load_pending_i,
        output logic [`REG_ADDR_W-1:0]          rs_addr_o,
        output logic [`REG_ADDR_W-1:0]          rt_addr_o,
        output logic                            stall_o,
        output mips_pkg::id_ex_t                id_ex_o
);

import mips_pkg::*;

opcode_e                opcode;
funct_e                 funct;
logic [`REG_ADDR_W-1:0] rs;
logic [`REG_ADDR_W-1:0] rt;
logic [`REG_ADDR_W-1:0] rd;
logic [`REG_ADDR_W-1:0] shamt;
logic [15:0]            imm;
alu_op_e                alu_op;
mem_op_e                mem_op;
logic                   we;
logic [`REG_ADDR_W-1:0] dest;
logic                   use_rs;
logic                   use_rt;
logic                   imm_op;
logic                   zero_ext;
logic                   shift_op;
logic [`REG_W-1:0]      rs_val;
logic [`REG_W-1:0]      rt_val;
logic [`REG_W-1:0]      imm_val;
id_ex_t                 id_ex_d;

// EX first, then MEM, then the register file
function automatic logic [`REG_W-1:0] bypass_sel(input logic [`REG_ADDR_W-1:0] addr,
                                                 input logic [`REG_W-1:0] rf_data);
        if (ex_bypass_i.we && !ex_load_pending_i && ex_bypass_i.dest == addr)
                return ex_bypass_i.value;
        if (mem_bypass_i.we && mem_bypass_i.dest == addr)
                return mem_bypass_i.value;
        return rf_data;
endfunction

assign opcode = opcode_e'(if_id_i.inst[`OPCODE_MSB:`OPCODE_LSB]);
assign funct  = funct_e'(if_id_i.inst[`FUNCT_MSB:`FUNCT_LSB]);
assign rs     = if_id_i.inst[`RS_MSB:`RS_LSB];
assign rt     = if_id_i.inst[`RT_MSB:`RT_LSB];
assign rd     = if_id_i.inst[`RD_MSB:`RD_LSB];
assign shamt  = if_id_i.inst[`SHAMT_MSB:`SHAMT_LSB];
assign imm    = if_id_i.inst[`IMM_MSB:`IMM_LSB];

always_comb
begin
        alu_op   = ALU_ADD;
        mem_op   = MEM_NONE;
        we       = 1'b0;
        dest     = rt;
        use_rs   = 1'b1;
        use_rt   = 1'b0;
        imm_op   = 1'b1;
        zero_ext = 1'b0;
        shift_op = 1'b0;
        case (opcode)
        OP_SPECIAL:
        begin
                dest   = rd;
                we     = 1'b1;
                use_rt = 1'b1;
                imm_op = 1'b0;
                case (funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLL, FN_SRL, FN_SRA:
                begin
                        shift_op = 1'b1;
                        use_rs   = 1'b0;
                        if (funct == FN_SLL)
                                alu_op = ALU_SLL;
                        else if (funct == FN_SRL)
                                alu_op = ALU_SRL;
                        else
                                alu_op = ALU_SRA;
                end
                default:
                begin
                        we     = 1'b0;
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                end
                endcase
        end
        OP_ADDIU: we = 1'b1;
        OP_ANDI, OP_ORI, OP_XORI:
        begin
                we       = 1'b1;
                zero_ext = 1'b1;
                if (opcode == OP_ANDI)
                        alu_op = ALU_AND;
                else if (opcode == OP_ORI)
                        alu_op = ALU_OR;
                else
                        alu_op = ALU_XOR;
        end
        OP_LUI:
        begin
                we     = 1'b1;
                use_rs = 1'b0;
                alu_op = ALU_LUI;
        end
        OP_LW:
        begin
                we     = 1'b1;
                mem_op = MEM_LOAD;
        end
        OP_SW:
        begin
                use_rt = 1'b1;
                mem_op = MEM_STORE;
        end
        // unknown opcode becomes a bubble
        default: use_rs = 1'b0;
        endcase
        // r0 is never written
        if (dest == '0)
                we = 1'b0;
end

always_comb
begin
        rs_val = bypass_sel(rs, rs_data_i);
        rt_val = bypass_sel(rt, rt_data_i);
end

assign imm_val = zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

always_comb
begin
        id_ex_d.pc         = if_id_i.pc;
        id_ex_d.alu_op     = alu_op;
        id_ex_d.mem_op     = mem_op;
        id_ex_d.op_a       = shift_op ? {{(`REG_W-`REG_ADDR_W){1'b0}}, shamt} : rs_val;
        id_ex_d.op_b       = imm_op ? imm_val : rt_val;
        id_ex_d.store_data = rt_val;
        id_ex_d.we         = we;
        id_ex_d.dest       = dest;
end

assign rs_addr_o = rs;
assign rt_addr_o = rt;

// load in EX whose result this instruction needs
assign stall_o = ex_load_pending_i && ex_bypass_i.we &&
                 ((use_rs && ex_bypass_i.dest == rs) || (use_rt && ex_bypass_i.dest == rt));

always_ff @(posedge clk)
begin
        id_ex_o <= id_ex_d;
        if (rst_i || stall_o)
        begin
                id_ex_o.we     <= 1'b0;
                id_ex_o.mem_op <= MEM_NONE;
        end
end

endmodule

`default_nettype wire

//--- source/regfile.sv
// 32 x 32 register file with write-through read ports
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module regfile (
        input  wire                             clk,
        input  wire                             rst_i,
        input  wire mips_pkg::wb_debug_t        wb_i,
        input  wire [`REG_ADDR_W-1:0]           rs_addr_i,
        input  wire [`REG_ADDR_W-1:0]           rt_addr_i,
        output logic [`REG_W-1:0]               rs_data_o,
        output logic [`REG_W-1:0]               rt_data_o
);

logic [`REG_W-1:0] regs [0:(1<<`REG_ADDR_W)-1];

// value being written back is visible in the same cycle
function automatic logic [`REG_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
                return '0;
        if (wb_i.we && wb_i.dest == addr)
                return wb_i.data;
        return regs[addr];
endfunction

always_ff @(posedge clk)
begin
        if (!rst_i && wb_i.we && wb_i.dest != '0)
                regs[wb_i.dest] <= wb_i.data;
end

always_comb
begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// alu, address generation and the EX/MEM register
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module execute_stage (
        input  wire                     clk,
        input  wire                     rst_i,
        input  wire mips_pkg::id_ex_t   id_ex_i,
        output mips_pkg::bypass_t       ex_bypass_o,
        output logic                    ex_load_pending_o,
        output mips_pkg::ex_mem_t       ex_mem_o
);

import mips_pkg::*;

logic [`REG_W-1:0]      a;
logic [`REG_W-1:0]      b;
logic [`REG_ADDR_W-1:0] shamt;
logic [`REG_W-1:0]      result;

assign a     = id_ex_i.op_a;
assign b     = id_ex_i.op_b;
assign shamt = a[`REG_ADDR_W-1:0];

always_comb
begin
        case (id_ex_i.alu_op)
        ALU_ADD: result = a + b;
        ALU_SUB: result = a - b;
        ALU_AND: result = a & b;
        ALU_OR:  result = a | b;
        ALU_XOR: result = a ^ b;
        ALU_NOR: result = ~(a | b);
        ALU_SLT: result = {{(`REG_W-1){1'b0}}, $signed(a) < $signed(b)};
        ALU_SLL: result = b << shamt;
        ALU_SRL: result = b >> shamt;
        ALU_SRA: result = $signed(b) >>> shamt;
        ALU_LUI: result = {b[15:0], 16'b0};
        default: result = '0;
        endcase
end

// a load's value is not ready here, decode must wait on it
assign ex_load_pending_o = (id_ex_i.mem_op == MEM_LOAD);

always_comb
begin
        ex_bypass_o.we    = id_ex_i.we;
        ex_bypass_o.dest  = id_ex_i.dest;
        ex_bypass_o.value = result;
end

always_ff @(posedge clk)
begin
        ex_mem_o.pc         <= id_ex_i.pc;
        ex_mem_o.result     <= result;
        ex_mem_o.store_data <= id_ex_i.store_data;
        ex_mem_o.dest       <= id_ex_i.dest;
        if (rst_i)
        begin
                ex_mem_o.we     <= 1'b0;
                ex_mem_o.mem_op <= MEM_NONE;
        end
        else
        begin
                ex_mem_o.we     <= id_ex_i.we;
                ex_mem_o.mem_op <= id_ex_i.mem_op;
        end
end

endmodule

`default_nettype wire

//--- source/memory_stage.sv
// data memory request, load select and the MEM/WB register
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module memory_stage (
        input  wire                     clk,
        input  wire                     rst_i,
        input  wire mips_pkg::ex_mem_t  ex_mem_i,
        input  wire [`REG_W-1:0]        ram_data_i,
        output mips_pkg::dmem_req_t     dmem_req_o,
        output mips_pkg::bypass_t       mem_bypass_o,
        output mips_pkg::wb_debug_t     wb_o
);

import mips_pkg::*;

logic [`REG_W-1:0] wb_value;

always_comb
begin
        dmem_req_o.ce    = (ex_mem_i.mem_op != MEM_NONE);
        dmem_req_o.we    = (ex_mem_i.mem_op == MEM_STORE);
        dmem_req_o.addr  = ex_mem_i.result;
        dmem_req_o.wdata = ex_mem_i.store_data;
end

// ram answers in the same cycle
assign wb_value = (ex_mem_i.mem_op == MEM_LOAD) ? ram_data_i : ex_mem_i.result;

always_comb
begin
        mem_bypass_o.we    = ex_mem_i.we;
        mem_bypass_o.dest  = ex_mem_i.dest;
        mem_bypass_o.value = wb_value;
end

always_ff @(posedge clk)
begin
        wb_o.pc   <= ex_mem_i.pc;
        wb_o.dest <= ex_mem_i.dest;
        wb_o.data <= wb_value;
        if (rst_i)
                wb_o.we <= 1'b0;
        else
                wb_o.we <= ex_mem_i.we;
end

endmodule

`default_nettype wire

//--- source/openmips.sv
// core top level connecting the five stages, register file and memory ports
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module openmips (
        input  wire                     clk,
        input  wire                     rst_i,
        input  wire [`REG_W-1:0]        rom_data_i,
        output logic [`REG_W-1:0]       rom_addr_o,
        output logic                    rom_ce_o,
        input  wire [`REG_W-1:0]        ram_data_i,
        output mips_pkg::dmem_req_t     dmem_req_o,
        output mips_pkg::wb_debug_t     debug_wb_o
);

import mips_pkg::*;

if_id_t                 if_id;
id_ex_t                 id_ex;
ex_mem_t                ex_mem;
bypass_t                ex_bypass;
bypass_t                mem_bypass;
logic                   ex_load_pending;
logic                   stall;
logic [`REG_ADDR_W-1:0] rs_addr;
logic [`REG_ADDR_W-1:0] rt_addr;
logic [`REG_W-1:0]      rs_data;
logic [`REG_W-1:0]      rt_data;

fetch_stage fetch0 (
        .clk(clk), .rst_i(rst_i), .stall_i(stall),
        .rom_data_i(rom_data_i), .rom_addr_o(rom_addr_o),
        .rom_ce_o(rom_ce_o), .if_id_o(if_id)
);

decode_stage decode0 (
        .clk(clk), .rst_i(rst_i), .if_id_i(if_id),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .ex_bypass_i(ex_bypass), .mem_bypass_i(mem_bypass),
        .ex_load_pending_i(ex_load_pending),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
        .stall_o(stall), .id_ex_o(id_ex)
);

// writeback bus doubles as the debug port
regfile regfile0 (
        .clk(clk), .rst_i(rst_i), .wb_i(debug_wb_o),
        .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
        .rs_data_o(rs_data), .rt_data_o(rt_data)
);

execute_stage execute0 (
        .clk(clk), .rst_i(rst_i), .id_ex_i(id_ex),
        .ex_bypass_o(ex_bypass), .ex_load_pending_o(ex_load_pending),
        .ex_mem_o(ex_mem)
);

memory_stage memory0 (
        .clk(clk), .rst_i(rst_i), .ex_mem_i(ex_mem),
        .ram_data_i(ram_data_i), .dmem_req_o(dmem_req_o),
        .mem_bypass_o(mem_bypass), .wb_o(debug_wb_o)
);

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// testbench clock source and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
        parameter int PERIOD       = 100,
        parameter int RESET_CYCLES = 2
) (
        output logic clk_o,
        output logic rst_o
);

initial
begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
end

// reset drops on a falling edge, like every other input
initial
begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
end

endmodule

`default_nettype wire

//--- test/tb_openmips.sv
// testbench for the core: program table, memory models, writeback and store checks
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module tb_openmips;

import mips_pkg::*;

localparam int WAIT_LIMIT = 20;

localparam logic [5:0] OP_ADDIU_C = 6'h09;
localparam logic [5:0] OP_ANDI_C  = 6'h0c;
localparam logic [5:0] OP_ORI_C   = 6'h0d;
localparam logic [5:0] OP_XORI_C  = 6'h0e;
localparam logic [5:0] OP_LUI_C   = 6'h0f;
localparam logic [5:0] OP_LW_C    = 6'h23;
localparam logic [5:0] OP_SW_C    = 6'h2b;
localparam logic [5:0] FN_SLL_C   = 6'h00;
localparam logic [5:0] FN_SRL_C   = 6'h02;
localparam logic [5:0] FN_SRA_C   = 6'h03;
localparam logic [5:0] FN_ADDU_C  = 6'h21;
localparam logic [5:0] FN_SUBU_C  = 6'h23;
localparam logic [5:0] FN_AND_C   = 6'h24;
localparam logic [5:0] FN_OR_C    = 6'h25;
localparam logic [5:0] FN_XOR_C   = 6'h26;
localparam logic [5:0] FN_NOR_C   = 6'h27;
localparam logic [5:0] FN_SLT_C   = 6'h2a;

// one program word with what it must produce
typedef struct packed {
        logic [31:0]    inst;
        logic           writes;
        logic [4:0]     dest;
        logic [31:0]    value;
        logic           stores;
        logic [31:0]    addr;
        logic [31:0]    data;
} entry_t;

logic           clk;
logic           rst;
logic [31:0]    rom_data;
logic [31:0]    rom_addr;
logic           rom_ce;
logic [31:0]    ram_data;
dmem_req_t      dmem_req;
wb_debug_t      debug_wb;

entry_t         prog [$];
wb_debug_t      wb_q [$];
dmem_req_t      st_q [$];
logic [31:0]    rom [0:63];
logic [31:0]    ram [0:255];

tb_clock_gen clock0 (
        .clk_o(clk),
        .rst_o(rst)
);

openmips uut (
        .clk(clk),
        .rst_i(rst),
        .rom_data_i(rom_data),
        .rom_addr_o(rom_addr),
        .rom_ce_o(rom_ce),
        .ram_data_i(ram_data),
        .dmem_req_o(dmem_req),
        .debug_wb_o(debug_wb)
);

// words past the program read as nop
assign rom_data = (rom_ce == 1'b1 && rom_addr[31:8] == '0) ? rom[rom_addr[7:2]] : 32'h0;
assign ram_data = (dmem_req.ce == 1'b1 && dmem_req.we == 1'b0) ?
                  ram[dmem_req.addr[9:2]] : 32'h0;

always @(posedge clk)
begin
        if (dmem_req.ce == 1'b1 && dmem_req.we == 1'b1)
                ram[dmem_req.addr[9:2]] <= dmem_req.wdata;
end

// collect retirements and stores as they happen
always @(negedge clk)
begin
        if (debug_wb.we == 1'b1)
                wb_q.push_back(debug_wb);
        if (dmem_req.ce == 1'b1 && dmem_req.we == 1'b1)
                st_q.push_back(dmem_req);
end

function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
endfunction

// initial ram word derived from the full byte address
function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
endfunction

task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
endtask

task automatic add_write(input logic [31:0] inst, input logic [4:0] dest,
                         input logic [31:0] value);
        prog.push_back('{inst, 1'b1, dest, value, 1'b0, 32'h0, 32'h0});
endtask

task automatic add_silent(input logic [31:0] inst);
        prog.push_back('{inst, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 32'h0});
endtask

task automatic add_store(input logic [31:0] inst, input logic [31:0] addr,
                         input logic [31:0] data);
        prog.push_back('{inst, 1'b0, 5'd0, 32'h0, 1'b1, addr, data});
endtask

task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        add_write(enc_i(OP_ORI_C, 5'd0, 5'd1, 16'h1234), 5'd1, 32'h0000_1234);
        add_write(enc_i(OP_LUI_C, 5'd0, 5'd2, 16'h8765), 5'd2, 32'h8765_0000);
        add_write(enc_i(OP_ADDIU_C, 5'd0, 5'd3, 16'hfffb), 5'd3, 32'hffff_fffb);
        add_write(enc_i(OP_ANDI_C, 5'd3, 5'd4, 16'h00f0), 5'd4, 32'h0000_00f0);
        add_write(enc_i(OP_XORI_C, 5'd1, 5'd5, 16'hffff), 5'd5, 32'h0000_edcb);
        add_write(enc_i(OP_ORI_C, 5'd2, 5'd2, 16'h4321), 5'd2, 32'h8765_4321);
        // r2 now reaches distances 1, 2 and 3
        add_write(enc_r(FN_ADDU_C, 5'd1, 5'd2, 5'd6, 5'd0), 5'd6, 32'h8765_5555);
        add_write(enc_r(FN_SUBU_C, 5'd1, 5'd2, 5'd7, 5'd0), 5'd7, 32'h789a_cf13);
        add_write(enc_r(FN_AND_C, 5'd2, 5'd3, 5'd8, 5'd0), 5'd8, 32'h8765_4321);
        add_write(enc_r(FN_OR_C, 5'd1, 5'd4, 5'd9, 5'd0), 5'd9, 32'h0000_12f4);
        add_write(enc_r(FN_XOR_C, 5'd6, 5'd7, 5'd10, 5'd0), 5'd10, 32'hffff_9a46);
        add_write(enc_r(FN_NOR_C, 5'd1, 5'd0, 5'd11, 5'd0), 5'd11, 32'hffff_edcb);
        add_write(enc_r(FN_SLT_C, 5'd2, 5'd1, 5'd12, 5'd0), 5'd12, 32'h0000_0001);
        add_write(enc_r(FN_SLT_C, 5'd1, 5'd2, 5'd13, 5'd0), 5'd13, 32'h0000_0000);
        add_write(enc_r(FN_SLL_C, 5'd0, 5'd1, 5'd14, 5'd4), 5'd14, 32'h0001_2340);
        add_write(enc_r(FN_SRL_C, 5'd0, 5'd2, 5'd15, 5'd8), 5'd15, 32'h0087_6543);
        add_write(enc_r(FN_SRA_C, 5'd0, 5'd2, 5'd16, 5'd8), 5'd16, 32'hff87_6543);
        // r0 target is dropped, and r0 still reads zero right after
        add_silent(enc_i(OP_ADDIU_C, 5'd1, 5'd0, 16'h0001));
        add_write(enc_r(FN_ADDU_C, 5'd0, 5'd1, 5'd17, 5'd0), 5'd17, 32'h0000_1234);
        add_store(enc_i(OP_SW_C, 5'd4, 5'd6, 16'h0010), 32'h0000_0100, 32'h8765_5555);
        add_write(enc_i(OP_LW_C, 5'd0, 5'd18, 16'h0100), 5'd18, 32'h8765_5555);
        add_write(enc_r(FN_ADDU_C, 5'd18, 5'd1, 5'd19, 5'd0), 5'd19, 32'h8765_6789);
        add_write(enc_i(OP_LW_C, 5'd0, 5'd20, 16'h0020), 5'd20, fill_word(32'h20));
        add_store(enc_i(OP_SW_C, 5'd0, 5'd20, 16'h0024), 32'h0000_0024, fill_word(32'h20));
        add_write(enc_i(OP_LW_C, 5'd0, 5'd21, 16'h0024), 5'd21, fill_word(32'h20));
        add_write(enc_r(FN_SUBU_C, 5'd21, 5'd20, 5'd22, 5'd0), 5'd22, 32'h0);
        for (int k = 0; k < 3; k++)
        begin
                a = $urandom;
                b = $urandom;
                add_write(enc_i(OP_LUI_C, 5'd0, 5'd23, a[31:16]), 5'd23, {a[31:16], 16'h0});
                add_write(enc_i(OP_ORI_C, 5'd23, 5'd23, a[15:0]), 5'd23, a);
                add_write(enc_i(OP_LUI_C, 5'd0, 5'd24, b[31:16]), 5'd24, {b[31:16], 16'h0});
                add_write(enc_i(OP_ORI_C, 5'd24, 5'd24, b[15:0]), 5'd24, b);
                add_write(enc_r(FN_ADDU_C, 5'd23, 5'd24, 5'd25, 5'd0), 5'd25, a + b);
                add_write(enc_r(FN_SUBU_C, 5'd23, 5'd24, 5'd26, 5'd0), 5'd26, a - b);
                add_write(enc_r(FN_XOR_C, 5'd25, 5'd26, 5'd27, 5'd0), 5'd27,
                          (a + b) ^ (a - b));
        end
endtask

task automatic check_reset();
        int low_cycles;
        low_cycles = 0;
        @(posedge clk);
        @(negedge clk);
        while (rom_ce != 1'b1)
        begin
                if (dmem_req.ce != 1'b0 || dmem_req.we != 1'b0 || debug_wb.we != 1'b0)
                        abort_run("memory strobe or writeback active during reset");
                low_cycles++;
                if (low_cycles >= WAIT_LIMIT)
                        abort_run("timed out waiting for instruction fetch to start");
                @(negedge clk);
        end
        if (low_cycles < 2)
                abort_run("instruction fetch started before reset was over");
        if (rom_addr != `RESET_PC)
        begin
                $display("FAILED rom_addr_o: got %h, expected %h", rom_addr, `RESET_PC);
                abort_run("first fetch address is wrong");
        end
endtask

task automatic next_writeback(output wb_debug_t got);
        int cycles;
        cycles = 0;
        while (wb_q.size() == 0)
        begin
                if (cycles >= WAIT_LIMIT)
                        abort_run("timed out waiting for a register writeback");
                @(negedge clk);
                cycles++;
        end
        got = wb_q.pop_front();
endtask

task automatic next_store(output dmem_req_t got);
        int cycles;
        cycles = 0;
        while (st_q.size() == 0)
        begin
                if (cycles >= WAIT_LIMIT)
                        abort_run("timed out waiting for a data memory store");
                @(negedge clk);
                cycles++;
        end
        got = st_q.pop_front();
endtask

task automatic check_wb(input wb_debug_t got, input wb_debug_t exp);
        logic bad;
        bad = 1'b0;
        if (got.pc != exp.pc)
        begin
                $display("FAILED debug_wb_o.pc: got %h, expected %h", got.pc, exp.pc);
                bad = 1'b1;
        end
        if (got.dest != exp.dest)
        begin
                $display("FAILED debug_wb_o.dest: got %h, expected %h", got.dest, exp.dest);
                bad = 1'b1;
        end
        if (got.data != exp.data)
        begin
                $display("FAILED debug_wb_o.data: got %h, expected %h", got.data, exp.data);
                bad = 1'b1;
        end
        if (bad)
                abort_run("register writeback does not match the program");
endtask

task automatic check_dmem(input dmem_req_t got, input dmem_req_t exp);
        logic bad;
        bad = 1'b0;
        if (got.addr != exp.addr)
        begin
                $display("FAILED dmem_req_o.addr: got %h, expected %h", got.addr, exp.addr);
                bad = 1'b1;
        end
        if (got.wdata != exp.wdata)
        begin
                $display("FAILED dmem_req_o.wdata: got %h, expected %h", got.wdata, exp.wdata);
                bad = 1'b1;
        end
        if (bad)
                abort_run("data memory store does not match the program");
endtask

task automatic run_table();
        entry_t         e;
        wb_debug_t      got_wb;
        wb_debug_t      exp_wb;
        dmem_req_t      got_req;
        dmem_req_t      exp_req;
        for (int i = 0; i < prog.size(); i++)
        begin
                e = prog[i];
                if (e.writes)
                begin
                        exp_wb.pc   = 32'(i * 4);
                        exp_wb.we   = 1'b1;
                        exp_wb.dest = e.dest;
                        exp_wb.data = e.value;
                        next_writeback(got_wb);
                        check_wb(got_wb, exp_wb);
                end
                if (e.stores)
                begin
                        exp_req.ce    = 1'b1;
                        exp_req.we    = 1'b1;
                        exp_req.addr  = e.addr;
                        exp_req.wdata = e.data;
                        next_store(got_req);
                        check_dmem(got_req, exp_req);
                end
        end
endtask

initial
begin
        void'($urandom(82));
        build_program();
        for (int i = 0; i < 64; i++)
                rom[i[5:0]] = (i < prog.size()) ? prog[i].inst : 32'h0;
        for (int i = 0; i < 256; i++)
                ram[i[7:0]] = fill_word(32'(i * 4));
        check_reset();
        run_table();
        // trailing nops retire nothing
        repeat (8) @(negedge clk);
        if (wb_q.size() != 0 || st_q.size() != 0)
        begin
                abort_run("unexpected writeback or store after the last instruction");
        end
        else
        begin
                $display("Result: PASSED");
                $finish;
        end
end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/mips_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/regfile.sv
source/execute_stage.sv
source/memory_stage.sv
source/openmips.sv
test/tb_clock_gen.sv
test/tb_openmips.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --timing --timescale 1ns/1ps
TOP       = tb_openmips
RTL_TOP   = openmips
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep "^Result: PASSED$$" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
